// File: fetchStage.f
source/fetchMemPkg.sv
source/branchPkg.sv
source/branchTargetBuffer.sv
source/directionPredictor.sv
source/returnAddressStack.sv
source/instCache.sv
source/fetchStage.sv
testbench/fetchStageTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
# Exit status is nonzero when the build or any check fails
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module fetchStageTb \
  -f fetchStage.f \
  -o fetchStageSim \
  && ./obj_dir/fetchStageSim \
  || { echo "fetch stage simulation did not pass"; exit 1; }

// File: source/branchPkg.sv
package branchPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Control instruction types
  ////////////////////////////////////////////////////////////////////////////

  localparam int BR_TYPE_W = 2;

  localparam logic [BR_TYPE_W-1:0] BR_RETURN = 2'd0;
  localparam logic [BR_TYPE_W-1:0] BR_CALL   = 2'd1;
  localparam logic [BR_TYPE_W-1:0] BR_JUMP   = 2'd2;
  // Only type that consults the direction counters
  localparam logic [BR_TYPE_W-1:0] BR_COND   = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Table geometry
  ////////////////////////////////////////////////////////////////////////////

  // Four slot entries per set
  localparam int BTB_SETS = 4;

  // Counters indexed by word address bits 7:2
  localparam int BP_ENTRIES = 64;
  localparam int BP_INDEX_W = 6;
  localparam int BP_CTR_W   = 2;
  // Weakly not taken
  localparam logic [BP_CTR_W-1:0] BP_INIT = 2'd1;

  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

endpackage

// File: source/branchTargetBuffer.sv
`timescale 1ns/1ps

module branchTargetBuffer (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic [fetchMemPkg::ADDR_W-1:0]              lookupPc_i,
  input  logic                                        updateEn_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]              updatePc_i,
  input  logic [branchPkg::BR_TYPE_W-1:0]             updateType_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]              updateTarget_i,
  output logic [fetchMemPkg::FETCH_WIDTH-1:0]         hit_o,
  output logic [fetchMemPkg::FETCH_WIDTH-1:0][branchPkg::BR_TYPE_W-1:0] brType_o,
  output logic [fetchMemPkg::FETCH_WIDTH-1:0][fetchMemPkg::ADDR_W-1:0]  target_o
);
  import fetchMemPkg::*;
  import branchPkg::*;

  // Per set and slot entry state
  logic [BTB_SETS-1:0][FETCH_WIDTH-1:0] validArr;
  logic [BTB_TAG_W-1:0] tagArr    [BTB_SETS][FETCH_WIDTH];
  logic [BR_TYPE_W-1:0] typeArr   [BTB_SETS][FETCH_WIDTH];
  logic [ADDR_W-1:0]    targetArr [BTB_SETS][FETCH_WIDTH];

  fetchAddr_u lookAddr;
  fetchAddr_u updAddr;
  logic [SLOT_W-1:0] updSlot;

  assign lookAddr = lookupPc_i;
  assign updAddr  = updatePc_i;
  // Slot is the word position inside the bundle
  assign updSlot  = updAddr.btb.offset[LINE_OFFSET_W-1:LINE_OFFSET_W-SLOT_W];

  ////////////////////////////////////////////////////////////////////////////
  // Lookup, all four slots of one set at once
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      hit_o[s]    = validArr[lookAddr.btb.btbIndex][s] &&
                    (tagArr[lookAddr.btb.btbIndex][s] == lookAddr.btb.btbTag);
      brType_o[s] = typeArr[lookAddr.btb.btbIndex][s];
      target_o[s] = targetArr[lookAddr.btb.btbIndex][s];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Update, one entry per cycle
  ////////////////////////////////////////////////////////////////////////////

  // Valid bits start cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      validArr <= '0;
    end else if (updateEn_i) begin
      validArr[updAddr.btb.btbIndex][updSlot] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagArr[updAddr.btb.btbIndex][updSlot]    <= updAddr.btb.btbTag;
      typeArr[updAddr.btb.btbIndex][updSlot]   <= updateType_i;
      targetArr[updAddr.btb.btbIndex][updSlot] <= updateTarget_i;
    end
  end

endmodule

// File: source/directionPredictor.sv
`timescale 1ns/1ps

module directionPredictor (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [fetchMemPkg::ADDR_W-1:0]      lookupPc_i,
  input  logic                                updateEn_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]      updatePc_i,
  input  logic                                updateTaken_i,
  output logic [fetchMemPkg::FETCH_WIDTH-1:0] taken_o
);
  import fetchMemPkg::*;
  import branchPkg::*;

  logic [BP_CTR_W-1:0]   counters [BP_ENTRIES];
  logic [BP_INDEX_W-1:0] trainIdx;
  logic [BP_CTR_W-1:0]   trainCtr;

  // Word address bits select the counter
  assign trainIdx = updatePc_i[BP_INDEX_W+1:2];
  assign trainCtr = counters[trainIdx];

  // Four consecutive counters of the bundle
  // Upper bit set means 2 or 3, taken
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      taken_o[s] = counters[{lookupPc_i[BP_INDEX_W+1:LINE_OFFSET_W], SLOT_W'(s)}][BP_CTR_W-1];
    end
  end

  // Saturating train, one counter per update
  always_ff @(posedge clk) begin
    if (reset) begin
      counters <= '{default: BP_INIT};
    end else if (updateEn_i) begin
      if (updateTaken_i && (trainCtr != '1)) begin
        counters[trainIdx] <= trainCtr + BP_CTR_W'(1);
      end else if (!updateTaken_i && (trainCtr != '0)) begin
        counters[trainIdx] <= trainCtr - BP_CTR_W'(1);
      end
    end
  end

endmodule

// File: source/fetchMemPkg.sv
package fetchMemPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address and bundle geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W        = 32;
  localparam int INST_W        = 32;
  localparam int FETCH_WIDTH   = 4;
  localparam int BUNDLE_W      = INST_W * FETCH_WIDTH;
  // Slot number inside a bundle
  localparam int SLOT_W        = 2;
  // Byte offset inside one 16-byte bundle
  localparam int LINE_OFFSET_W = 4;

  // Instruction cache, one bundle per line
  localparam int ICACHE_LINES   = 16;
  localparam int ICACHE_INDEX_W = 4;
  localparam int ICACHE_TAG_W   = ADDR_W - ICACHE_INDEX_W - LINE_OFFSET_W;

  // BTB sets are indexed by bundle address
  localparam int BTB_INDEX_W = 2;
  localparam int BTB_TAG_W   = ADDR_W - BTB_INDEX_W - LINE_OFFSET_W;

  // Wishbone data beat
  localparam int WB_DAT_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // One fetch address, read as cache fields or as BTB fields
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ICACHE_TAG_W-1:0]   tag;
    logic [ICACHE_INDEX_W-1:0] index;
    logic [LINE_OFFSET_W-1:0]  offset;
  } cacheView_t;

  typedef struct packed {
    logic [BTB_TAG_W-1:0]     btbTag;
    logic [BTB_INDEX_W-1:0]   btbIndex;
    logic [LINE_OFFSET_W-1:0] offset;
  } btbView_t;

  typedef union packed {
    cacheView_t cache;
    btbView_t   btb;
  } fetchAddr_u;

endpackage

// File: source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stall_i,
  input  logic                                recoverEn_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]      recoverPc_i,
  input  logic                                updateEn_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]      updatePc_i,
  input  logic [fetchMemPkg::ADDR_W-1:0]      updateTarget_i,
  input  logic [branchPkg::BR_TYPE_W-1:0]     updateType_i,
  input  logic                                updateTaken_i,
  output logic                                wbCyc_o,
  output logic                                wbStb_o,
  output logic [fetchMemPkg::ADDR_W-1:0]      wbAdr_o,
  input  logic [fetchMemPkg::WB_DAT_W-1:0]    wbDat_i,
  input  logic                                wbAck_i,
  output logic                                fetchValid_o,
  output logic [fetchMemPkg::ADDR_W-1:0]      pc_o,
  output logic [fetchMemPkg::BUNDLE_W-1:0]    bundle_o,
  output logic [fetchMemPkg::FETCH_WIDTH-1:0] predTaken_o,
  output logic [fetchMemPkg::ADDR_W-1:0]      predTarget_o
);
  import fetchMemPkg::*;
  import branchPkg::*;

  logic [ADDR_W-1:0] pcReg;
  logic [ADDR_W-1:0] nextPc;

  // Lookup results per slot
  logic [FETCH_WIDTH-1:0]                btbHit;
  logic [FETCH_WIDTH-1:0][BR_TYPE_W-1:0] btbType;
  logic [FETCH_WIDTH-1:0][ADDR_W-1:0]    btbTarget;
  logic [FETCH_WIDTH-1:0]                dirTaken;
  logic [FETCH_WIDTH-1:0]                qualified;

  // Lowest redirecting slot
  logic [SLOT_W-1:0]    selSlot;
  logic [BR_TYPE_W-1:0] selType;
  logic                 anyRedirect;

  logic [ADDR_W-1:0] rasTop;
  logic [ADDR_W-1:0] rasPushAddr;
  logic              rasPush;
  logic              rasPop;

  logic btbWrEn;
  logic bpTrainEn;
  logic cacheHit;
  logic cacheHold;
  logic fetchAccept;

  ////////////////////////////////////////////////////////////////////////////
  // Table update qualification
  ////////////////////////////////////////////////////////////////////////////

  // Not-taken conditionals stay out of the BTB
  assign btbWrEn   = updateEn_i && !((updateType_i == BR_COND) && !updateTaken_i);
  assign bpTrainEn = updateEn_i && (updateType_i == BR_COND);

  branchTargetBuffer btb (
    .clk           (clk),
    .reset         (reset),
    .lookupPc_i    (pcReg),
    .updateEn_i    (btbWrEn),
    .updatePc_i    (updatePc_i),
    .updateType_i  (updateType_i),
    .updateTarget_i(updateTarget_i),
    .hit_o         (btbHit),
    .brType_o      (btbType),
    .target_o      (btbTarget)
  );

  directionPredictor bp (
    .clk          (clk),
    .reset        (reset),
    .lookupPc_i   (pcReg),
    .updateEn_i   (bpTrainEn),
    .updatePc_i   (updatePc_i),
    .updateTaken_i(updateTaken_i),
    .taken_o      (dirTaken)
  );

  returnAddressStack ras (
    .clk       (clk),
    .reset     (reset),
    .push_i    (rasPush),
    .pop_i     (rasPop),
    .pushAddr_i(rasPushAddr),
    .top_o     (rasTop)
  );

  // Address holds unless a recovery overrides it
  assign cacheHold = !recoverEn_i;

  instCache icache (
    .clk     (clk),
    .reset   (reset),
    .addr_i  (pcReg),
    .hold_i  (cacheHold),
    .hit_o   (cacheHit),
    .bundle_o(bundle_o),
    .wbCyc_o (wbCyc_o),
    .wbStb_o (wbStb_o),
    .wbAdr_o (wbAdr_o),
    .wbDat_i (wbDat_i),
    .wbAck_i (wbAck_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slot qualification and next PC
  ////////////////////////////////////////////////////////////////////////////

  // Conditionals redirect only when predicted taken
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      qualified[s] = btbHit[s] && ((btbType[s] != BR_COND) || dirTaken[s]);
    end
  end

  // Scan downward so the lowest slot wins
  always_comb begin
    selSlot = '0;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
      if (qualified[s]) begin
        selSlot = SLOT_W'(s);
      end
    end
  end

  assign anyRedirect = |qualified;
  assign selType     = btbType[selSlot];
  // Isolate lowest set bit
  assign predTaken_o = qualified & (~qualified + FETCH_WIDTH'(1));

  // Returns take the RAS top, no redirect falls through
  assign predTarget_o = !anyRedirect ? pcReg + ADDR_W'(16) :
                        (selType == BR_RETURN) ? rasTop : btbTarget[selSlot];
  assign nextPc       = recoverEn_i ? recoverPc_i : predTarget_o;

  assign fetchValid_o = cacheHit;
  assign fetchAccept  = fetchValid_o && !stall_i;

  // Return address is the word after the call slot
  assign rasPushAddr = {pcReg[ADDR_W-1:LINE_OFFSET_W], selSlot, 2'b00} + ADDR_W'(4);
  assign rasPush     = fetchAccept && anyRedirect && (selType == BR_CALL);
  assign rasPop      = fetchAccept && anyRedirect && (selType == BR_RETURN);

  // Recovery wins over stall and miss
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (recoverEn_i || fetchAccept) begin
      pcReg <= {nextPc[ADDR_W-1:LINE_OFFSET_W], LINE_OFFSET_W'(0)};
    end
  end

  assign pc_o = pcReg;

  // Mask and slot scan agree on the lowest redirecting slot
  predTakenOneHot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(predTaken_o) && (predTaken_o[selSlot] == anyRedirect)
  );

  // Bundle alignment holds across every PC source
  pcAligned : assert property (
    @(posedge clk) disable iff (reset) pc_o[LINE_OFFSET_W-1:0] == '0
  );

endmodule

// File: source/instCache.sv
`timescale 1ns/1ps

module instCache (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [fetchMemPkg::ADDR_W-1:0]   addr_i,
  input  logic                             hold_i,
  output logic                             hit_o,
  output logic [fetchMemPkg::BUNDLE_W-1:0] bundle_o,
  output logic                             wbCyc_o,
  output logic                             wbStb_o,
  output logic [fetchMemPkg::ADDR_W-1:0]   wbAdr_o,
  input  logic [fetchMemPkg::WB_DAT_W-1:0] wbDat_i,
  input  logic                             wbAck_i
);
  import fetchMemPkg::*;

  // Tag, valid and data arrays
  logic [ICACHE_LINES-1:0] validArr;
  logic [ICACHE_TAG_W-1:0] tagArr  [ICACHE_LINES];
  logic [BUNDLE_W-1:0]     dataArr [ICACHE_LINES];

  fetchAddr_u lookAddr;
  fetchAddr_u fillAddr;

  // Refill FSM, idle or fetching beats
  logic              filling;
  logic [SLOT_W-1:0] beatCnt;
  // First three words, word 0 ends up lowest
  logic [BUNDLE_W-WB_DAT_W-1:0] fillBuf;

  logic lineHit;
  logic startFill;
  logic lastBeat;

  assign lookAddr = addr_i;
  assign lineHit  = validArr[lookAddr.cache.index] &&
                    (tagArr[lookAddr.cache.index] == lookAddr.cache.tag);
  assign bundle_o = dataArr[lookAddr.cache.index];

  // hold_i low means a recovery replaces addr_i on this edge
  assign hit_o     = lineHit && !filling && hold_i;
  assign startFill = !lineHit && !filling && hold_i;
  assign lastBeat  = filling && wbAck_i && (beatCnt == SLOT_W'(FETCH_WIDTH - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone classic read master
  ////////////////////////////////////////////////////////////////////////////

  assign wbCyc_o = filling;
  assign wbStb_o = filling;
  // Word address of the current beat, byte bits zero
  assign wbAdr_o = {fillAddr.cache.tag, fillAddr.cache.index, beatCnt, 2'b00};

  always_ff @(posedge clk) begin
    if (reset) begin
      filling  <= 1'b0;
      beatCnt  <= '0;
      validArr <= '0;
    end else if (startFill) begin
      filling <= 1'b1;
      beatCnt <= '0;
    end else if (filling && wbAck_i) begin
      beatCnt <= beatCnt + SLOT_W'(1);
      if (lastBeat) begin
        // Fourth ack ends the cycle and validates the line
        filling                          <= 1'b0;
        validArr[fillAddr.cache.index]   <= 1'b1;
      end
    end
  end

  // Line address, beat assembly and array write
  always_ff @(posedge clk) begin
    if (startFill) begin
      fillAddr <= lookAddr;
    end
    if (filling && wbAck_i) begin
      fillBuf <= {wbDat_i, fillBuf[BUNDLE_W-WB_DAT_W-1:WB_DAT_W]};
    end
    if (lastBeat) begin
      dataArr[fillAddr.cache.index] <= {wbDat_i, fillBuf};
      tagArr[fillAddr.cache.index]  <= fillAddr.cache.tag;
    end
  end

  // Strobe only inside a cycle, request held steady until ack
  wbRequestHeld : assert property (
    @(posedge clk) disable iff (reset)
    wbStb_o && !wbAck_i |=> wbStb_o && wbCyc_o && $stable(wbAdr_o)
  );

endmodule

// File: source/returnAddressStack.sv
`timescale 1ns/1ps

module returnAddressStack (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push_i,
  input  logic                           pop_i,
  input  logic [fetchMemPkg::ADDR_W-1:0] pushAddr_i,
  output logic [fetchMemPkg::ADDR_W-1:0] top_o
);
  import fetchMemPkg::*;
  import branchPkg::*;

  logic [ADDR_W-1:0]    stack [RAS_DEPTH];
  // Points at the current top entry
  logic [RAS_PTR_W-1:0] topPtr;
  logic [RAS_PTR_W-1:0] pushPtr;

  // Wraps past the last entry, oldest return is lost
  assign pushPtr = topPtr + RAS_PTR_W'(1);
  assign top_o   = stack[topPtr];

  // Empty stack reads as zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      stack  <= '{default: '0};
    end else if (push_i) begin
      topPtr         <= pushPtr;
      stack[pushPtr] <= pushAddr_i;
    end else if (pop_i) begin
      // Underflow just wraps, entry keeps its old value
      topPtr <= topPtr - RAS_PTR_W'(1);
    end
  end

  // Call and return never come from the same slot
  pushPopExclusive : assert property (
    @(posedge clk) disable iff (reset) !(push_i && pop_i)
  );

endmodule

// File: testbench/fetchStageTb.sv
`timescale 1ns/1ps

module fetchStageTb;
  import fetchMemPkg::*;
  import branchPkg::*;

  localparam int NUM_TESTS   = 1000;
  // Three cycles per test, room for refills and stalls
  localparam int CYCLE_LIMIT = NUM_TESTS * 3;
  localparam int DRAIN_LIMIT = 64;
  localparam int BTB_ENTRIES = BTB_SETS * FETCH_WIDTH;

  logic                   clk;
  logic                   reset;
  logic                   stall;
  logic                   recoverEn;
  logic [ADDR_W-1:0]      recoverPc;
  logic                   updateEn;
  logic [ADDR_W-1:0]      updatePc;
  logic [ADDR_W-1:0]      updateTarget;
  logic [BR_TYPE_W-1:0]   updateType;
  logic                   updateTaken;
  logic                   wbCyc;
  logic                   wbStb;
  logic [ADDR_W-1:0]      wbAdr;
  logic [WB_DAT_W-1:0]    wbDat;
  logic                   wbAck;
  logic                   fetchValid;
  logic [ADDR_W-1:0]      pc;
  logic [BUNDLE_W-1:0]    bundle;
  logic [FETCH_WIDTH-1:0] predTaken;
  logic [ADDR_W-1:0]      predTarget;

  // Reference tables, BTB entry index is set * 4 + slot
  logic                 mValid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] mTag    [BTB_ENTRIES];
  logic [BR_TYPE_W-1:0] mType   [BTB_ENTRIES];
  logic [ADDR_W-1:0]    mTarget [BTB_ENTRIES];
  logic [BP_CTR_W-1:0]  mCtr    [BP_ENTRIES];
  logic [ADDR_W-1:0]    mRas    [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] mRasTop;

  // Reference cache tags and refill state
  logic                    mLineValid [ICACHE_LINES];
  logic [ICACHE_TAG_W-1:0] mLineTag   [ICACHE_LINES];
  logic                    mFilling;
  logic                    expValid;

  // Model prediction for the current PC
  logic [FETCH_WIDTH-1:0] expMask;
  logic [ADDR_W-1:0]      expTarget;
  logic [BR_TYPE_W-1:0]   selType;
  logic                   selFound;
  int                     selSlot;

  logic [ADDR_W-1:0]   expPc;
  logic [BUNDLE_W-1:0] heldBundle;
  logic                holdPending;
  logic [31:0]         rngState;
  int                  cycleCount;

  // Memory responder state
  int                ackDelay;
  int                beatIdx;
  logic [ADDR_W-1:0] lineBase;

  fetchStage fetchStage_i (
    .clk           (clk),
    .reset         (reset),
    .stall_i       (stall),
    .recoverEn_i   (recoverEn),
    .recoverPc_i   (recoverPc),
    .updateEn_i    (updateEn),
    .updatePc_i    (updatePc),
    .updateTarget_i(updateTarget),
    .updateType_i  (updateType),
    .updateTaken_i (updateTaken),
    .wbCyc_o       (wbCyc),
    .wbStb_o       (wbStb),
    .wbAdr_o       (wbAdr),
    .wbDat_i       (wbDat),
    .wbAck_i       (wbAck),
    .fetchValid_o  (fetchValid),
    .pc_o          (pc),
    .bundle_o      (bundle),
    .predTaken_o   (predTaken),
    .predTarget_o  (predTarget)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and memory contents
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] drawRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // Word is a scrambled copy of its own address
  function automatic logic [WB_DAT_W-1:0] memWord(input logic [ADDR_W-1:0] addr);
    return xorshift32(addr ^ 32'h5bd1e995);
  endfunction

  // Word 0 in the low bits
  function automatic logic [BUNDLE_W-1:0] lineWords(input logic [ADDR_W-1:0] base);
    logic [BUNDLE_W-1:0] words;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      words[i*INST_W +: INST_W] = memWord(base + ADDR_W'(4 * i));
    end
    return words;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic checkAddr(input string name, input fetchAddr_u got, input fetchAddr_u exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkBundle(input string name, input logic [BUNDLE_W-1:0] got,
                             input logic [BUNDLE_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkMask(input string name, input logic [FETCH_WIDTH-1:0] got,
                           input logic [FETCH_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference predictor
  ////////////////////////////////////////////////////////////////////////////

  // First slot that hits and redirects wins
  task automatic predictModel();
    fetchAddr_u a;
    int idx;
    int ctrIdx;
    a = expPc;
    expMask   = '0;
    expTarget = expPc + ADDR_W'(16);
    selFound  = 1'b0;
    selSlot   = 0;
    selType   = BR_JUMP;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      idx    = int'(a.btb.btbIndex) * FETCH_WIDTH + s;
      ctrIdx = int'(expPc[BP_INDEX_W+1:LINE_OFFSET_W]) * FETCH_WIDTH + s;
      if (!selFound && mValid[idx] && (mTag[idx] == a.btb.btbTag) &&
          ((mType[idx] != BR_COND) || (mCtr[ctrIdx] >= BP_CTR_W'(2)))) begin
        selFound   = 1'b1;
        selSlot    = s;
        selType    = mType[idx];
        expMask[s] = 1'b1;
        expTarget  = (mType[idx] == BR_RETURN) ? mRas[mRasTop] : mTarget[idx];
      end
    end
  endtask

  // Same edge as the DUT tables
  task automatic applyUpdate();
    fetchAddr_u u;
    int idx;
    int ci;
    u   = updatePc;
    idx = int'(u.btb.btbIndex) * FETCH_WIDTH + int'(u.btb.offset[3:2]);
    ci  = int'(updatePc[BP_INDEX_W+1:2]);
    // Not-taken conditionals never enter the BTB
    if (updateEn && !((updateType == BR_COND) && !updateTaken)) begin
      mValid[idx]  = 1'b1;
      mTag[idx]    = u.btb.btbTag;
      mType[idx]   = updateType;
      mTarget[idx] = updateTarget;
    end
    if (updateEn && (updateType == BR_COND)) begin
      if (updateTaken && (mCtr[ci] != 2'd3)) begin
        mCtr[ci] = mCtr[ci] + BP_CTR_W'(1);
      end else if (!updateTaken && (mCtr[ci] != 2'd0)) begin
        mCtr[ci] = mCtr[ci] - BP_CTR_W'(1);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One cycle, entered and left on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic runCycle(input logic quiet);
    logic [31:0]         r1;
    logic [31:0]         r2;
    logic                accepted;
    logic                nextAck;
    logic [WB_DAT_W-1:0] nextDat;
    logic                lineHit;
    fetchAddr_u          pa;
    fetchAddr_u          fa;
    checkAddr("pc_o", pc, expPc);
    predictModel();
    checkMask("predTaken_o", predTaken, expMask);
    checkAddr("predTarget_o", predTarget, expTarget);

    // Hit needs a valid tag, no refill and no recovery
    pa       = expPc;
    lineHit  = mLineValid[pa.cache.index] && (mLineTag[pa.cache.index] == pa.cache.tag);
    expValid = lineHit && !mFilling && !recoverEn;
    checkFlag("fetchValid_o", fetchValid, expValid);
    checkFlag("wbCyc_o", wbCyc, mFilling);
    if (holdPending) begin
      checkBundle("bundle_o", bundle, heldBundle);
    end
    if (expValid) begin
      checkBundle("bundle_o", bundle, lineWords(expPc));
    end

    // Memory responder, ack 1 to 4 cycles after the strobe
    if (wbStb && !wbCyc) begin
      $display("Wishbone strobe raised outside a bus cycle");
      abortRun();
    end
    nextAck = 1'b0;
    nextDat = '0;
    if (wbStb && !wbAck && (beatIdx < FETCH_WIDTH)) begin
      if (ackDelay == 0) begin
        checkAddr("wbAdr_o", wbAdr, lineBase + ADDR_W'(4 * beatIdx));
        nextAck  = 1'b1;
        nextDat  = memWord(wbAdr);
        beatIdx  = beatIdx + 1;
        ackDelay = int'(drawRand() & 32'h3);
      end else begin
        ackDelay = ackDelay - 1;
      end
    end

    // Fourth ack writes the line, a miss starts a refill
    if (mFilling && wbAck && (beatIdx == FETCH_WIDTH)) begin
      fa                         = lineBase;
      mFilling                   = 1'b0;
      mLineValid[fa.cache.index] = 1'b1;
      mLineTag[fa.cache.index]   = fa.cache.tag;
    end else if (!mFilling && !lineHit && !recoverEn) begin
      mFilling = 1'b1;
      lineBase = expPc;
      beatIdx  = 0;
    end

    accepted = expValid && !stall;
    // Call pushes the word after its slot
    if (accepted && selFound && (selType == BR_CALL)) begin
      mRasTop       = mRasTop + RAS_PTR_W'(1);
      mRas[mRasTop] = expPc + ADDR_W'(4 * selSlot + 4);
    end else if (accepted && selFound && (selType == BR_RETURN)) begin
      mRasTop = mRasTop - RAS_PTR_W'(1);
    end

    // Expected PC after the next edge, recovery first
    if (recoverEn) begin
      expPc = {recoverPc[ADDR_W-1:LINE_OFFSET_W], LINE_OFFSET_W'(0)};
    end else if (accepted) begin
      expPc = {expTarget[ADDR_W-1:LINE_OFFSET_W], LINE_OFFSET_W'(0)};
    end
    holdPending = expValid && stall;
    heldBundle  = bundle;
    applyUpdate();

    r1 = drawRand();
    r2 = drawRand();
    @(posedge clk);
    stall        <= !quiet && (r1[1:0] == 2'b00);
    recoverEn    <= !quiet && (r1[5:2] == 4'h0);
    recoverPc    <= ADDR_W'(r1[16:8]);
    updateEn     <= !quiet && r2[0];
    // Small window so lookups hit the trained entries
    updatePc     <= ADDR_W'({r2[6:1], 2'b00});
    updateType   <= r2[8:7];
    // Mostly taken, counters climb into the taken half
    updateTaken  <= r2[9] || r2[10];
    updateTarget <= ADDR_W'(r2[19:11]);
    wbAck        <= nextAck;
    wbDat        <= nextDat;
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int drain;
    rngState     = 32'h472a5f6f;
    reset        = 1'b1;
    stall        = 1'b0;
    recoverEn    = 1'b0;
    recoverPc    = '0;
    updateEn     = 1'b0;
    updatePc     = '0;
    updateTarget = '0;
    updateType   = BR_RETURN;
    updateTaken  = 1'b0;
    wbDat        = '0;
    wbAck        = 1'b0;
    expPc        = '0;
    heldBundle   = '0;
    holdPending  = 1'b0;
    ackDelay     = 0;
    beatIdx      = 0;
    lineBase     = '0;
    mRasTop      = '0;
    mFilling     = 1'b0;
    expValid     = 1'b0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      mValid[i]  = 1'b0;
      mTag[i]    = '0;
      mType[i]   = BR_RETURN;
      mTarget[i] = '0;
    end
    for (int i = 0; i < BP_ENTRIES; i++) begin
      mCtr[i] = BP_INIT;
    end
    for (int i = 0; i < RAS_DEPTH; i++) begin
      mRas[i] = '0;
    end
    for (int i = 0; i < ICACHE_LINES; i++) begin
      mLineValid[i] = 1'b0;
      mLineTag[i]   = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkFlag("fetchValid_o", fetchValid, 1'b0);
    checkFlag("wbCyc_o", wbCyc, 1'b0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      runCycle(1'b0);
    end
    // Quiet cycles until an open refill completes
    drain = 0;
    while (wbCyc && (drain < DRAIN_LIMIT)) begin
      runCycle(1'b1);
      drain = drain + 1;
    end
    if (wbCyc) begin
      $display("Wishbone cycle left open at the end of the run");
      abortRun();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount = cycleCount + 1;
    end
    $display("Timeout after %0d cycles before the tests finished", cycleCount);
    abortRun();
  end

endmodule
